/* vlog.f */
src/planner_pkg.sv
src/stream_fifo.sv
src/space_arbiter.sv
src/space_allocator.sv
src/packet_planner.sv
verif/planner_props.sv
verif/planner_tb.sv

/* Bender.yml */
package:
  name: packet_planner

sources:
  # Synthesizable RTL, package first
  - files:
      - src/planner_pkg.sv
      - src/stream_fifo.sv
      - src/space_arbiter.sv
      - src/space_allocator.sv
      - src/packet_planner.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verif/planner_props.sv
      - verif/planner_tb.sv

/* verif/planner_tb.sv */
////////////////////
// Packet space planner testbench
// Directed tests with a reference address model and scoreboard
////////////////////

`default_nettype none

module planner_tb
    import planner_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NS       = DEF_NUM_STREAMS;
    localparam int META_W   = DEF_META_W;
    localparam int LEN_W    = DEF_LEN_W;
    localparam int SPACE    = DEF_SPACE_SIZE;
    localparam int ALIGN    = DEF_ALIGN;
    localparam int GAP      = DEF_GAP_SIZE;
    localparam int DEPTH    = DEF_FIFO_DEPTH;
    localparam int AOFF     = DEF_AFULL_OFFSET;
    localparam int PTR_W    = space_ptr_w(SPACE);
    localparam int STREAM_W = $clog2(NS);

    // The timeout allows twice the summed cycle budget of the tests
    localparam int RESET_CYCLES   = 8;
    localparam int TEST_CYCLES    = 20 + 200 + 200 + 200 + 600 + 200;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + TEST_CYCLES);

    logic                   clk;
    logic                   rst_n;
    logic [NS-1:0]          in_valid;
    logic [NS-1:0]          in_ready;
    logic [NS*META_W-1:0]   in_meta;
    logic [NS*LEN_W-1:0]    in_len;
    logic [NS-1:0]          in_afull;
    logic [PTR_W-1:0]       space_rd_ptr;
    logic [PTR_W-1:0]       space_wr_ptr;
    logic                   out_valid;
    logic                   out_ready;
    logic [STREAM_W-1:0]    out_stream;
    logic [META_W-1:0]      out_meta;
    logic [LEN_W-1:0]       out_len;
    logic [PTR_W-2:0]       out_addr;

    // Reference write pointer and scoreboard of packets not yet seen
    int ref_ptr;
    bit auto_free;
    int errors;
    int tests_run;
    int tests_failed;
    int cycles;
    int exp_stream[$];
    int exp_meta[$];
    int exp_len[$];
    int seen_stream[$];

    packet_planner dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles because the DUT stopped responding",
                 cycles);
        $display("Errors found");
        $finish;
    end

    // Packet length plus gap rounded up to the alignment
    function automatic int step_of(int len);
        return ((len + GAP + ALIGN - 1) / ALIGN) * ALIGN;
    endfunction

    task automatic report_mismatch(string name, int got, int exp);
        $display("Fail t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        errors++;
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // Matches an output against the oldest pending packet of its stream
    task automatic check_output();
        int idx;
        idx = -1;
        for (int i = 0; i < exp_stream.size(); i++) begin
            if (idx < 0 && exp_stream[i] == int'(out_stream)) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("Packet from stream %0d at t=%0t was never sent", out_stream, $time);
            errors++;
        end else begin
            if (out_meta !== META_W'(exp_meta[idx]))
                report_mismatch("out_meta", out_meta, exp_meta[idx]);
            if (out_len !== LEN_W'(exp_len[idx]))
                report_mismatch("out_len", out_len, exp_len[idx]);
            if (int'(out_addr) != ref_ptr % SPACE)
                report_mismatch("out_addr", out_addr, ref_ptr % SPACE);
            ref_ptr = (ref_ptr + step_of(exp_len[idx])) % (2 * SPACE);
            // Until this packet leaves, the write pointer sits just past it
            if (int'(space_wr_ptr) != ref_ptr)
                report_mismatch("space_wr_ptr", space_wr_ptr, ref_ptr);
            exp_stream.delete(idx);
            exp_meta.delete(idx);
            exp_len.delete(idx);
        end
        seen_stream.push_back(int'(out_stream));
    endtask

    // The output monitor also acts as the consumer and frees space as soon
    // as a packet leaves
    initial begin
        forever begin
            @(posedge clk);
            if (rst_n && out_valid && out_ready) begin
                check_output();
                if (auto_free) begin
                    #1;
                    space_rd_ptr = PTR_W'(ref_ptr);
                end
            end
        end
    end

    task automatic push_desc(int s, int len, int meta);
        bit done;
        in_valid[s] = 1'b1;
        in_len[s*LEN_W +: LEN_W] = LEN_W'(len);
        in_meta[s*META_W +: META_W] = META_W'(meta);
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = in_ready[s];
            #1;
        end
        in_valid[s] = 1'b0;
        exp_stream.push_back(s);
        exp_meta.push_back(meta);
        exp_len.push_back(len);
    endtask

    task automatic wait_drained(int limit);
        int n;
        n = 0;
        while (exp_stream.size() != 0 && n < limit) begin
            tick();
            n++;
        end
        if (exp_stream.size() != 0) begin
            $display("%0d packets still missing at t=%0t", exp_stream.size(), $time);
            errors++;
            exp_stream.delete();
            exp_meta.delete();
            exp_len.delete();
        end
    endtask

    task automatic wait_out_valid(int limit);
        int n;
        n = 0;
        while (!out_valid && n < limit) begin
            tick();
            n++;
        end
        if (!out_valid) begin
            $display("No output appeared within %0d cycles at t=%0t", limit, $time);
            errors++;
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic test_reset_values();
        int e0;
        e0 = errors;
        if (out_valid !== 1'b0) report_mismatch("out_valid", out_valid, 0);
        if (in_afull !== '0) report_mismatch("in_afull", in_afull, 0);
        if (in_ready !== '1) report_mismatch("in_ready", in_ready, (1 << NS) - 1);
        if (space_wr_ptr !== '0) report_mismatch("space_wr_ptr", space_wr_ptr, 0);
        finish_test("reset values", e0);
    endtask

    task automatic test_single_stream();
        int e0;
        e0 = errors;
        seen_stream.delete();
        for (int i = 0; i < 6; i++) begin
            push_desc(0, $urandom_range(200, 1), $urandom_range(255, 0));
        end
        wait_drained(100);
        if (seen_stream.size() != 6) begin
            $display("Stream 0 gave %0d packets instead of 6", seen_stream.size());
            errors++;
        end
        finish_test("single stream addresses", e0);
    endtask

    task automatic test_round_robin();
        int e0;
        e0 = errors;
        seen_stream.delete();
        out_ready = 1'b0;
        for (int r = 0; r < 2; r++) begin
            for (int s = 0; s < NS; s++) begin
                push_desc(s, $urandom_range(200, 1), $urandom_range(255, 0));
            end
        end
        out_ready = 1'b1;
        wait_drained(100);
        if (seen_stream.size() != 2 * NS) begin
            $display("Round-robin run gave %0d packets instead of %0d",
                     seen_stream.size(), 2 * NS);
            errors++;
        end
        for (int i = 0; i < seen_stream.size(); i++) begin
            if (seen_stream[i] != i % NS)
                report_mismatch("out_stream", seen_stream[i], i % NS);
        end
        finish_test("round-robin order", e0);
    endtask

    task automatic test_back_pressure();
        int e0;
        logic [STREAM_W-1:0] hold_stream;
        logic [META_W-1:0]   hold_meta;
        logic [LEN_W-1:0]    hold_len;
        logic [PTR_W-2:0]    hold_addr;
        logic [PTR_W-1:0]    hold_wr_ptr;
        e0 = errors;
        seen_stream.delete();
        out_ready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            push_desc(1 + i % 2, $urandom_range(200, 1), $urandom_range(255, 0));
        end
        wait_out_valid(20);
        hold_stream = out_stream;
        hold_meta = out_meta;
        hold_len = out_len;
        hold_addr = out_addr;
        hold_wr_ptr = space_wr_ptr;
        repeat (20) begin
            tick();
            if (out_valid !== 1'b1) report_mismatch("out_valid", out_valid, 1);
            if (out_stream !== hold_stream) report_mismatch("out_stream", out_stream, hold_stream);
            if (out_meta !== hold_meta) report_mismatch("out_meta", out_meta, hold_meta);
            if (out_len !== hold_len) report_mismatch("out_len", out_len, hold_len);
            if (out_addr !== hold_addr) report_mismatch("out_addr", out_addr, hold_addr);
            if (space_wr_ptr !== hold_wr_ptr)
                report_mismatch("space_wr_ptr", space_wr_ptr, hold_wr_ptr);
        end
        out_ready = 1'b1;
        wait_drained(100);
        if (seen_stream.size() != 4) begin
            $display("Back-pressure run gave %0d packets instead of 4", seen_stream.size());
            errors++;
        end
        finish_test("back-pressure", e0);
    endtask

    task automatic test_space_wrap();
        int e0;
        int rd_model;
        int used;
        int len;
        bit full;
        e0 = errors;
        auto_free = 1'b0;
        rd_model = ref_ptr;
        space_rd_ptr = PTR_W'(rd_model);
        full = 1'b0;
        len = 0;
        while (!full) begin
            len = $urandom_range(200, 1);
            used = (ref_ptr - rd_model + 2 * SPACE) % (2 * SPACE);
            if (used + step_of(len) > SPACE) begin
                full = 1'b1;
            end else begin
                push_desc(0, len, $urandom_range(255, 0));
                wait_drained(50);
            end
        end
        push_desc(2, len, $urandom_range(255, 0));
        repeat (20) begin
            tick();
            if (out_valid !== 1'b0) report_mismatch("out_valid", out_valid, 0);
        end
        // Freeing the whole space lets the stalled packet through
        space_rd_ptr = PTR_W'(ref_ptr);
        wait_drained(50);
        auto_free = 1'b1;
        space_rd_ptr = PTR_W'(ref_ptr);
        finish_test("space exhaustion and wrap", e0);
    endtask

    task automatic test_queue_flags();
        int e0;
        e0 = errors;
        out_ready = 1'b0;
        // A packet parked in the output register keeps stream 0 from draining
        push_desc(3, $urandom_range(200, 1), $urandom_range(255, 0));
        wait_out_valid(20);
        for (int k = 1; k <= DEPTH; k++) begin
            push_desc(0, $urandom_range(200, 1), $urandom_range(255, 0));
            if (in_afull[0] !== (k >= DEPTH - AOFF))
                report_mismatch("in_afull[0]", in_afull[0], k >= DEPTH - AOFF);
            if (in_ready[0] !== (k < DEPTH))
                report_mismatch("in_ready[0]", in_ready[0], k < DEPTH);
        end
        out_ready = 1'b1;
        wait_drained(100);
        if (in_afull[0] !== 1'b0) report_mismatch("in_afull[0]", in_afull[0], 0);
        if (in_ready[0] !== 1'b1) report_mismatch("in_ready[0]", in_ready[0], 1);
        finish_test("queue flags", e0);
    endtask

    initial begin
        void'($urandom(32'h909b_b393));
        rst_n = 1'b0;
        in_valid = '0;
        in_meta = '0;
        in_len = '0;
        space_rd_ptr = '0;
        out_ready = 1'b0;
        auto_free = 1'b1;
        ref_ptr = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick();
        test_reset_values();
        out_ready = 1'b1;
        test_single_stream();
        test_round_robin();
        test_back_pressure();
        test_space_wrap();
        test_queue_flags();
        // Failed bound assertions count as errors of the run
        errors += dut0.props0.fail_count;
        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/planner_props.sv */
////////////////////
// Packet space planner assertions
// Output hold, space bound and address alignment
////////////////////

`default_nettype none

module planner_props
    import planner_pkg::*;
#(
    parameter int NUM_STREAMS = DEF_NUM_STREAMS,
    parameter int META_W      = DEF_META_W,
    parameter int LEN_W       = DEF_LEN_W,
    parameter int SPACE_SIZE  = DEF_SPACE_SIZE,
    parameter int ALIGN       = DEF_ALIGN,
    localparam int STREAM_W   = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1,
    localparam int PTR_W      = space_ptr_w(SPACE_SIZE),
    localparam int ADDR_W     = PTR_W - 1
) (
    input logic                clk,
    input logic                rst_n,
    input logic                out_valid,
    input logic                out_ready,
    input logic [STREAM_W-1:0] out_stream,
    input logic [META_W-1:0]   out_meta,
    input logic [LEN_W-1:0]    out_len,
    input logic [ADDR_W-1:0]   out_addr,
    input logic [PTR_W-1:0]    space_wr_ptr,
    input logic [PTR_W-1:0]    space_rd_ptr
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [PTR_W-1:0] used;

    // Number of assertion failures so far
    int fail_count = 0;

    assign used = space_wr_ptr - space_rd_ptr;

    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_stream) && $stable(out_meta)
            && $stable(out_len) && $stable(out_addr))
        else begin
            $error("Output changed while the consumer stalled");
            fail_count++;
        end

    space_bound: assert property (@(posedge clk) disable iff (!rst_n)
        used <= PTR_W'(SPACE_SIZE))
        else begin
            $error("Used space is beyond the space size");
            fail_count++;
        end

    addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_addr & ADDR_W'(ALIGN - 1)) == '0)
        else begin
            $error("Output address is not aligned");
            fail_count++;
        end

endmodule

bind packet_planner planner_props #(
    .NUM_STREAMS (NUM_STREAMS),
    .META_W      (META_W),
    .LEN_W       (LEN_W),
    .SPACE_SIZE  (SPACE_SIZE),
    .ALIGN       (ALIGN)
) props0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_stream   (out_stream),
    .out_meta     (out_meta),
    .out_len      (out_len),
    .out_addr     (out_addr),
    .space_wr_ptr (space_wr_ptr),
    .space_rd_ptr (space_rd_ptr)
);

`default_nettype wire

/* src/packet_planner.sv */
////////////////////
// Packet space planner top level
// Stream queues, round-robin arbiter and space allocator
////////////////////

`default_nettype none

module packet_planner
    import planner_pkg::*;
#(
    parameter int NUM_STREAMS  = DEF_NUM_STREAMS,
    parameter int META_W       = DEF_META_W,
    parameter int LEN_W        = DEF_LEN_W,
    parameter int SPACE_SIZE   = DEF_SPACE_SIZE,
    parameter int ALIGN        = DEF_ALIGN,
    parameter int GAP_SIZE     = DEF_GAP_SIZE,
    parameter int FIFO_DEPTH   = DEF_FIFO_DEPTH,
    parameter int AFULL_OFFSET = DEF_AFULL_OFFSET,
    localparam int STREAM_W    = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1,
    localparam int PTR_W       = space_ptr_w(SPACE_SIZE),
    localparam int ADDR_W      = PTR_W - 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [NUM_STREAMS-1:0]        in_valid,
    output logic [NUM_STREAMS-1:0]        in_ready,
    input  logic [NUM_STREAMS*META_W-1:0] in_meta,
    input  logic [NUM_STREAMS*LEN_W-1:0]  in_len,
    output logic [NUM_STREAMS-1:0]        in_afull,
    input  logic [PTR_W-1:0]              space_rd_ptr,
    output logic [PTR_W-1:0]              space_wr_ptr,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [STREAM_W-1:0]           out_stream,
    output logic [META_W-1:0]             out_meta,
    output logic [LEN_W-1:0]              out_len,
    output logic [ADDR_W-1:0]             out_addr
);

    logic [NUM_STREAMS-1:0]        head_valid;
    logic [NUM_STREAMS*META_W-1:0] head_meta;
    logic [NUM_STREAMS*LEN_W-1:0]  head_len;
    logic [NUM_STREAMS-1:0]        grant;
    logic [NUM_STREAMS-1:0]        pop;
    logic                          req_valid;
    logic [STREAM_W-1:0]           req_stream;
    logic [META_W-1:0]             req_meta;
    logic [LEN_W-1:0]              req_len;
    logic                          accept;

    // One descriptor queue per input stream
    for (genvar s = 0; s < NUM_STREAMS; s++) begin : g_stream
        // Only the granted queue loses its head, and only on accept
        assign pop[s] = grant[s] && accept;

        stream_fifo #(
            .META_W       (META_W),
            .LEN_W        (LEN_W),
            .DEPTH        (FIFO_DEPTH),
            .AFULL_OFFSET (AFULL_OFFSET)
        ) fifo_u (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_valid   (in_valid[s]),
            .in_ready   (in_ready[s]),
            .in_meta    (in_meta[s*META_W +: META_W]),
            .in_len     (in_len[s*LEN_W +: LEN_W]),
            .in_afull   (in_afull[s]),
            .pop        (pop[s]),
            .head_valid (head_valid[s]),
            .head_meta  (head_meta[s*META_W +: META_W]),
            .head_len   (head_len[s*LEN_W +: LEN_W])
        );
    end

    space_arbiter #(
        .NUM_STREAMS (NUM_STREAMS),
        .META_W      (META_W),
        .LEN_W       (LEN_W)
    ) arbiter_u (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_meta  (head_meta),
        .head_len   (head_len),
        .accept     (accept),
        .grant      (grant),
        .req_valid  (req_valid),
        .req_stream (req_stream),
        .req_meta   (req_meta),
        .req_len    (req_len)
    );

    space_allocator #(
        .NUM_STREAMS (NUM_STREAMS),
        .META_W      (META_W),
        .LEN_W       (LEN_W),
        .SPACE_SIZE  (SPACE_SIZE),
        .ALIGN       (ALIGN),
        .GAP_SIZE    (GAP_SIZE)
    ) allocator_u (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_stream   (req_stream),
        .req_meta     (req_meta),
        .req_len      (req_len),
        .accept       (accept),
        .space_rd_ptr (space_rd_ptr),
        .space_wr_ptr (space_wr_ptr),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_stream   (out_stream),
        .out_meta     (out_meta),
        .out_len      (out_len),
        .out_addr     (out_addr)
    );

endmodule

`default_nettype wire

/* src/space_allocator.sv */
////////////////////
// Space allocator
// Places each granted packet at the write pointer of the shared
// circular space and registers the planned packet for the output
////////////////////

`default_nettype none

module space_allocator
    import planner_pkg::*;
#(
    parameter int NUM_STREAMS = DEF_NUM_STREAMS,
    parameter int META_W      = DEF_META_W,
    parameter int LEN_W       = DEF_LEN_W,
    parameter int SPACE_SIZE  = DEF_SPACE_SIZE,
    parameter int ALIGN       = DEF_ALIGN,
    parameter int GAP_SIZE    = DEF_GAP_SIZE,
    localparam int STREAM_W   = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1,
    localparam int PTR_W      = space_ptr_w(SPACE_SIZE),
    localparam int ADDR_W     = PTR_W - 1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  logic [STREAM_W-1:0] req_stream,
    input  logic [META_W-1:0]   req_meta,
    input  logic [LEN_W-1:0]    req_len,
    output logic                accept,
    input  logic [PTR_W-1:0]    space_rd_ptr,
    output logic [PTR_W-1:0]    space_wr_ptr,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [STREAM_W-1:0] out_stream,
    output logic [META_W-1:0]   out_meta,
    output logic [LEN_W-1:0]    out_len,
    output logic [ADDR_W-1:0]   out_addr
);

    localparam logic [31:0] ALIGN_MASK = 32'(ALIGN - 1);
    localparam logic [31:0] SPACE_LIM  = 32'(SPACE_SIZE);

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] used;
    logic [31:0]      free_space;
    logic [31:0]      step;
    logic             out_free;
    logic             fits;

    // Packet length plus gap, rounded up to the next alignment boundary
    assign step = (32'(req_len) + 32'(GAP_SIZE) + ALIGN_MASK) & ~ALIGN_MASK;

    // The wrap bit makes the plain difference valid across the space end
    assign used       = wr_ptr - space_rd_ptr;
    assign free_space = SPACE_LIM - 32'(used);
    assign fits       = (step <= free_space);

    // The output register can take a packet when empty or emptied now
    assign out_free = !out_valid || out_ready;
    assign accept   = req_valid && out_free && fits;

    assign space_wr_ptr = wr_ptr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (accept) begin
                // An accepted step never exceeds the space, so it fits PTR_W
                wr_ptr    <= wr_ptr + step[PTR_W-1:0];
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // The planned packet register loads only on accept and so holds
    // while the consumer stalls
    always_ff @(posedge clk) begin
        if (accept) begin
            out_stream <= req_stream;
            out_meta   <= req_meta;
            out_len    <= req_len;
            out_addr   <= wr_ptr[ADDR_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* src/space_arbiter.sv */
////////////////////
// Round-robin arbiter over the stream queue heads
////////////////////

`default_nettype none

module space_arbiter
    import planner_pkg::*;
#(
    parameter int NUM_STREAMS = DEF_NUM_STREAMS,
    parameter int META_W      = DEF_META_W,
    parameter int LEN_W       = DEF_LEN_W,
    localparam int STREAM_W   = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [NUM_STREAMS-1:0]        head_valid,
    input  logic [NUM_STREAMS*META_W-1:0] head_meta,
    input  logic [NUM_STREAMS*LEN_W-1:0]  head_len,
    input  logic                          accept,
    output logic [NUM_STREAMS-1:0]        grant,
    output logic                          req_valid,
    output logic [STREAM_W-1:0]           req_stream,
    output logic [META_W-1:0]             req_meta,
    output logic [LEN_W-1:0]              req_len
);

    logic [STREAM_W-1:0] last;
    logic [STREAM_W-1:0] lock_sel;
    logic                locked;
    logic [STREAM_W-1:0] sel;
    logic                found;

    // Search starts one past the last accepted stream. A head that was
    // offered and stalled stays selected until it is accepted
    always_comb begin
        found = 1'b0;
        sel   = '0;
        if (locked) begin
            found = 1'b1;
            sel   = lock_sel;
        end else begin
            for (int i = 1; i <= NUM_STREAMS; i++) begin
                if (!found && head_valid[(int'(last) + i) % NUM_STREAMS]) begin
                    found = 1'b1;
                    sel   = STREAM_W'((int'(last) + i) % NUM_STREAMS);
                end
            end
        end
    end

    assign grant      = NUM_STREAMS'(found) << sel;
    assign req_valid  = found;
    assign req_stream = sel;
    assign req_meta   = head_meta[sel*META_W +: META_W];
    assign req_len    = head_len[sel*LEN_W +: LEN_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Stream 0 wins the first round
            last     <= STREAM_W'(NUM_STREAMS - 1);
            locked   <= 1'b0;
            lock_sel <= '0;
        end else begin
            if (accept) begin
                last <= sel;
            end
            locked   <= found && !accept;
            lock_sel <= sel;
        end
    end

endmodule

`default_nettype wire

/* src/stream_fifo.sv */
////////////////////
// Stream descriptor queue
// Circular register FIFO with almost-full flag and head output
////////////////////

`default_nettype none

module stream_fifo
    import planner_pkg::*;
#(
    parameter int META_W       = DEF_META_W,
    parameter int LEN_W        = DEF_LEN_W,
    parameter int DEPTH        = DEF_FIFO_DEPTH,
    parameter int AFULL_OFFSET = DEF_AFULL_OFFSET
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [META_W-1:0] in_meta,
    input  logic [LEN_W-1:0]  in_len,
    output logic              in_afull,
    input  logic              pop,
    output logic              head_valid,
    output logic [META_W-1:0] head_meta,
    output logic [LEN_W-1:0]  head_len
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [CNT_W-1:0] FULL_LVL  = CNT_W'(DEPTH);
    localparam logic [CNT_W-1:0] AFULL_LVL = CNT_W'(DEPTH - AFULL_OFFSET);
    localparam logic [IDX_W-1:0] LAST_IDX  = IDX_W'(DEPTH - 1);

    logic [META_W-1:0] meta_mem [DEPTH];
    logic [LEN_W-1:0]  len_mem  [DEPTH];

    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             do_pop;

    // Ready only drops on a completely full queue
    assign in_ready   = (count != FULL_LVL);
    assign in_afull   = (count >= AFULL_LVL);
    assign head_valid = (count != '0);
    assign head_meta  = meta_mem[rd_idx];
    assign head_len   = len_mem[rd_idx];

    assign push   = in_valid && in_ready;
    assign do_pop = pop && head_valid;

    // Descriptor storage
    always_ff @(posedge clk) begin
        if (push) begin
            meta_mem[wr_idx] <= in_meta;
            len_mem[wr_idx]  <= in_len;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_idx <= (wr_idx == LAST_IDX) ? '0 : wr_idx + 1'b1;
            end
            if (do_pop) begin
                rd_idx <= (rd_idx == LAST_IDX) ? '0 : rd_idx + 1'b1;
            end
            // A simultaneous push and pop leaves the fill level alone
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/planner_pkg.sv */
////////////////////
// Packet space planner shared definitions
// Default parameter values and the space pointer width helper
////////////////////

`default_nettype none

package planner_pkg;

    // Stream side defaults
    localparam int DEF_NUM_STREAMS  = 4;
    localparam int DEF_META_W       = 8;
    localparam int DEF_LEN_W        = 8;

    // Size and alignment of the circular space must be powers of two
    localparam int DEF_SPACE_SIZE   = 256;
    localparam int DEF_ALIGN        = 8;
    localparam int DEF_GAP_SIZE     = 4;

    // Descriptor queue defaults
    localparam int DEF_FIFO_DEPTH   = 4;
    localparam int DEF_AFULL_OFFSET = 1;

    // A space pointer holds the address bits plus one wrap bit so that a
    // full space and an empty space can be told apart
    function automatic int space_ptr_w(input int space_size);
        return $clog2(space_size) + 1;
    endfunction

endpackage

`default_nettype wire
